/* hdl/tlb_pkg.sv */
// Shared field widths and boot fill constants for the two-way data TLB
package tlb_pkg;

  // =========================================================================
  // Field types
  // =========================================================================

  typedef logic [31:0] vaddr_t;    // Virtual address from address generation
  typedef logic [6:0]  set_idx_t;  // Set index, address bits 22 to 16
  typedef logic [8:0]  vtag_t;     // Virtual tag, address bits 31 to 23
  typedef logic [7:0]  asid_t;     // Address space id
  typedef logic [15:0] ppn_t;      // Physical page number
  typedef logic [2:0]  rwx_t;      // Machine mode read, write and execute
  typedef logic [2:0]  rgn_t;      // Region number of the page
  typedef logic [5:0]  rob_ndx_t;  // Reorder buffer index of the memory op

  // =========================================================================
  // Boot fill
  // =========================================================================

  // The boot entries cover the top twelve sets, which map the ROM,
  // the IO space and the scratchpad at the very top of the address space
  localparam int    FILL_FIRST_SET = 116;
  localparam vtag_t FILL_TAG       = '1;        // All ones, top of memory
  localparam ppn_t  FILL_PPN_BASE  = 16'hFFF4;  // Page of set 116

  // Region codes used by the boot entries
  localparam rgn_t  RGN_ROM        = 3'd7;
  localparam rgn_t  RGN_IO         = 3'd6;
  localparam rgn_t  RGN_SCRATCH    = 3'd4;

endpackage

/* hdl/tlb_init_fill.sv */
// Boot fill of the upper TLB sets after reset and registered select of the write port
module tlb_init_fill #(
  parameter int TLB_SETS = 128
) (
  input  logic              clk,
  input  logic              rst,
  // External write port, ignored while the fill runs
  input  logic              wr_i,
  input  logic              way_i,
  input  tlb_pkg::set_idx_t set_i,
  input  tlb_pkg::vtag_t    tag_i,
  input  tlb_pkg::asid_t    asid_i,
  input  tlb_pkg::ppn_t     ppn_i,
  input  tlb_pkg::rwx_t     rwx_i,
  input  tlb_pkg::rgn_t     rgn_i,
  input  logic              v_i,
  // Write port into the entry storage, one cycle behind its source
  output logic              wr_o,
  output logic              way_o,
  output tlb_pkg::set_idx_t set_o,
  output tlb_pkg::vtag_t    tag_o,
  output tlb_pkg::asid_t    asid_o,
  output tlb_pkg::ppn_t     ppn_o,
  output tlb_pkg::rwx_t     rwx_o,
  output tlb_pkg::rgn_t     rgn_o,
  output logic              v_o,
  output logic              fill_done_o   // Stays high once the last boot entry is stored
);

  logic [7:0]    fill_cnt;   // Current boot set, stops at TLB_SETS
  logic          fill_busy;
  tlb_pkg::ppn_t fill_ppn;
  tlb_pkg::rgn_t fill_rgn;
  logic [7:0]    prev_cnt;   // Set before the current one, picks the region

  // With 128 sets the fill ends when the top counter bit sets
  assign fill_busy = fill_cnt < TLB_SETS;

  // One page per set, counting up from the base page
  assign fill_ppn = tlb_pkg::FILL_PPN_BASE
                  + tlb_pkg::ppn_t'(fill_cnt - 8'(tlb_pkg::FILL_FIRST_SET));

  // Region of the boot entry. The first set is ROM and the rest follow the
  // two middle bits of the preceding set number
  always_comb begin
    prev_cnt = fill_cnt - 8'd1;
    if (fill_cnt == 8'(tlb_pkg::FILL_FIRST_SET)) begin
      fill_rgn = tlb_pkg::RGN_ROM;
    end else begin
      case (prev_cnt[3:2])
        2'd1:    fill_rgn = tlb_pkg::RGN_IO;
        2'd2:    fill_rgn = tlb_pkg::RGN_SCRATCH;
        2'd3:    fill_rgn = tlb_pkg::RGN_ROM;
        default: fill_rgn = tlb_pkg::RGN_IO;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_cnt    <= 8'(tlb_pkg::FILL_FIRST_SET);
      fill_done_o <= 1'b0;
    end else begin
      if (fill_busy) begin
        fill_cnt <= fill_cnt + 8'd1;     // One boot entry per cycle
      end
      fill_done_o <= !fill_busy;         // Rises with the store of the last entry
    end
  end

  // =========================================================================
  // Write port select
  // =========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_o <= 1'b0;
    end else begin
      wr_o <= fill_busy | wr_i;          // The fill writes every cycle
    end
  end

  always_ff @(posedge clk) begin
    if (fill_busy) begin
      // Boot entries all go to way 0 with full machine permissions
      way_o  <= 1'b0;
      set_o  <= fill_cnt[6:0];
      tag_o  <= tlb_pkg::FILL_TAG;
      asid_o <= '0;
      ppn_o  <= fill_ppn;
      rwx_o  <= '1;
      rgn_o  <= fill_rgn;
      v_o    <= 1'b1;
    end else begin
      way_o  <= way_i;
      set_o  <= set_i;
      tag_o  <= tag_i;
      asid_o <= asid_i;
      ppn_o  <= ppn_i;
      rwx_o  <= rwx_i;
      rgn_o  <= rgn_i;
      v_o    <= v_i;
    end
  end

endmodule

/* hdl/tlb_ways.sv */
// Two-way TLB entry storage with one write port, a lookup read and a read-back read
module tlb_ways #(
  parameter int TLB_SETS = 128
) (
  input  logic              clk,
  input  logic              rst,
  // Write port, already registered by the fill block
  input  logic              wr_i,
  input  logic              way_i,
  input  tlb_pkg::set_idx_t set_i,
  input  tlb_pkg::vtag_t    tag_i,
  input  tlb_pkg::asid_t    asid_i,
  input  tlb_pkg::ppn_t     ppn_i,
  input  tlb_pkg::rwx_t     rwx_i,
  input  tlb_pkg::rgn_t     rgn_i,
  input  logic              v_i,
  input  tlb_pkg::set_idx_t look_set_i,   // Set of the current lookup
  input  tlb_pkg::set_idx_t rd_set_i,     // Read-back set
  input  logic              rd_way_i,     // Read-back way
  // Both ways of the lookup set
  output tlb_pkg::vtag_t    w0_tag_o,
  output tlb_pkg::asid_t    w0_asid_o,
  output tlb_pkg::ppn_t     w0_ppn_o,
  output tlb_pkg::rwx_t     w0_rwx_o,
  output tlb_pkg::rgn_t     w0_rgn_o,
  output logic              w0_v_o,
  output tlb_pkg::vtag_t    w1_tag_o,
  output tlb_pkg::asid_t    w1_asid_o,
  output tlb_pkg::ppn_t     w1_ppn_o,
  output tlb_pkg::rwx_t     w1_rwx_o,
  output tlb_pkg::rgn_t     w1_rgn_o,
  output logic              w1_v_o,
  // Selected read-back entry
  output tlb_pkg::vtag_t    rd_tag_o,
  output tlb_pkg::asid_t    rd_asid_o,
  output tlb_pkg::ppn_t     rd_ppn_o,
  output tlb_pkg::rwx_t     rd_rwx_o,
  output tlb_pkg::rgn_t     rd_rgn_o,
  output logic              rd_v_o
);

  // First index is the way, second the set
  tlb_pkg::vtag_t       tag_mem  [2][TLB_SETS];
  tlb_pkg::asid_t       asid_mem [2][TLB_SETS];
  tlb_pkg::ppn_t        ppn_mem  [2][TLB_SETS];
  tlb_pkg::rwx_t        rwx_mem  [2][TLB_SETS];
  tlb_pkg::rgn_t        rgn_mem  [2][TLB_SETS];
  logic [TLB_SETS-1:0]  v_mem    [2];          // Entry valid bits, one vector per way

  // Valid bits start clear so that sets outside the boot area miss
  always_ff @(posedge clk) begin
    if (rst) begin
      v_mem[0] <= '0;
      v_mem[1] <= '0;
    end else if (wr_i) begin
      v_mem[way_i][set_i] <= v_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_i) begin
      tag_mem[way_i][set_i]  <= tag_i;
      asid_mem[way_i][set_i] <= asid_i;
      ppn_mem[way_i][set_i]  <= ppn_i;
      rwx_mem[way_i][set_i]  <= rwx_i;
      rgn_mem[way_i][set_i]  <= rgn_i;
    end
  end

  // =========================================================================
  // Reads, both combinational
  // =========================================================================

  assign w0_tag_o  = tag_mem[0][look_set_i];
  assign w0_asid_o = asid_mem[0][look_set_i];
  assign w0_ppn_o  = ppn_mem[0][look_set_i];
  assign w0_rwx_o  = rwx_mem[0][look_set_i];
  assign w0_rgn_o  = rgn_mem[0][look_set_i];
  assign w0_v_o    = v_mem[0][look_set_i];

  assign w1_tag_o  = tag_mem[1][look_set_i];
  assign w1_asid_o = asid_mem[1][look_set_i];
  assign w1_ppn_o  = ppn_mem[1][look_set_i];
  assign w1_rwx_o  = rwx_mem[1][look_set_i];
  assign w1_rgn_o  = rgn_mem[1][look_set_i];
  assign w1_v_o    = v_mem[1][look_set_i];

  assign rd_tag_o  = tag_mem[rd_way_i][rd_set_i];    // Read-back for the page walker
  assign rd_asid_o = asid_mem[rd_way_i][rd_set_i];
  assign rd_ppn_o  = ppn_mem[rd_way_i][rd_set_i];
  assign rd_rwx_o  = rwx_mem[rd_way_i][rd_set_i];
  assign rd_rgn_o  = rgn_mem[rd_way_i][rd_set_i];
  assign rd_v_o    = v_mem[rd_way_i][rd_set_i];

endmodule

/* hdl/tlb_lookup.sv */
// TLB tag compare with a registered hit stage and a miss request toward the miss queue
module tlb_lookup (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid_i,      // Address generation has a memory op
  input  logic              stall_i,      // Downstream stage cannot take a result
  input  logic              load_i,
  input  logic              store_i,
  input  tlb_pkg::vaddr_t   vaddr_i,
  input  tlb_pkg::asid_t    asid_i,
  input  tlb_pkg::rob_ndx_t rob_i,
  // Both ways of the indexed set
  input  tlb_pkg::vtag_t    w0_tag_i,
  input  tlb_pkg::asid_t    w0_asid_i,
  input  tlb_pkg::ppn_t     w0_ppn_i,
  input  tlb_pkg::rwx_t     w0_rwx_i,
  input  tlb_pkg::rgn_t     w0_rgn_i,
  input  logic              w0_v_i,
  input  tlb_pkg::vtag_t    w1_tag_i,
  input  tlb_pkg::asid_t    w1_asid_i,
  input  tlb_pkg::ppn_t     w1_ppn_i,
  input  tlb_pkg::rwx_t     w1_rwx_i,
  input  tlb_pkg::rgn_t     w1_rgn_i,
  input  logic              w1_v_i,
  // Registered translation
  output logic              valid_o,
  output logic              load_o,
  output logic              store_o,
  output tlb_pkg::vaddr_t   vaddr_o,
  output tlb_pkg::rob_ndx_t rob_o,
  output tlb_pkg::ppn_t     ppn_o,
  output tlb_pkg::rwx_t     rwx_o,
  output tlb_pkg::rgn_t     rgn_o,
  // Miss request, one cycle strobe
  output logic              miss_req_o,
  output tlb_pkg::vaddr_t   miss_addr_o,
  output tlb_pkg::asid_t    miss_asid_o,
  output tlb_pkg::rob_ndx_t miss_rob_o
);

  tlb_pkg::vtag_t look_tag;
  logic           hit0;
  logic           hit1;
  logic           hit;
  logic           take;     // Lookup result goes into the output stage

  assign look_tag = vaddr_i[31:23];

  // An entry hits only with its valid bit set and both tag and asid equal
  assign hit0 = w0_v_i && (w0_tag_i == look_tag) && (w0_asid_i == asid_i);
  assign hit1 = w1_v_i && (w1_tag_i == look_tag) && (w1_asid_i == asid_i);
  assign hit  = hit0 | hit1;
  assign take = valid_i && !stall_i && hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= take;                   // High for one cycle per hit
    end
  end

  // Data holds during a stall or a miss
  always_ff @(posedge clk) begin
    if (take) begin
      vaddr_o <= vaddr_i;
      rob_o   <= rob_i;
      load_o  <= load_i;
      store_o <= store_i;
      if (hit0) begin                    // Way 0 wins when both match
        ppn_o <= w0_ppn_i;
        rwx_o <= w0_rwx_i;
        rgn_o <= w0_rgn_i;
      end else begin
        ppn_o <= w1_ppn_i;
        rwx_o <= w1_rwx_i;
        rgn_o <= w1_rgn_i;
      end
    end
  end

  // =========================================================================
  // Miss request
  // =========================================================================

  // The queue filters repeats, so a stalled-free miss is requested every time
  assign miss_req_o  = valid_i && !stall_i && !hit;
  assign miss_addr_o = vaddr_i;
  assign miss_asid_o = asid_i;
  assign miss_rob_o  = rob_i;

endmodule

/* hdl/tlb_miss_queue.sv */
// Circular TLB miss queue with duplicate filter, presenting its oldest miss to the page walker
module tlb_miss_queue #(
  parameter int MISSQ_ENTRIES = 16     // Power of two
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              miss_req_i,   // Lookup missed this cycle
  input  tlb_pkg::vaddr_t   req_addr_i,
  input  tlb_pkg::asid_t    req_asid_i,
  input  tlb_pkg::rob_ndx_t req_rob_i,
  input  logic              missack_i,    // Page walker took the head
  output logic              miss_o,       // Queue holds at least one miss
  output tlb_pkg::vaddr_t   miss_addr_o,
  output tlb_pkg::asid_t    miss_asid_o,
  output tlb_pkg::rob_ndx_t miss_rob_o
);

  localparam int PTR_W = $clog2(MISSQ_ENTRIES);

  tlb_pkg::vaddr_t   addr_q [MISSQ_ENTRIES];
  tlb_pkg::asid_t    asid_q [MISSQ_ENTRIES];
  tlb_pkg::rob_ndx_t rob_q  [MISSQ_ENTRIES];
  logic [PTR_W-1:0]  head;           // Oldest miss
  logic [PTR_W-1:0]  tail;           // Next free slot
  logic [PTR_W-1:0]  occupancy;
  logic              room;
  logic              in_queue;
  logic              push;
  logic              pop;

  // Three slots always stay free, so the pointers never wrap onto each other
  assign occupancy = tail - head;
  assign room      = occupancy < PTR_W'(MISSQ_ENTRIES - 3);

  // Look for the same address and asid among the live entries
  always_comb begin
    logic [PTR_W-1:0] offs;          // Distance of a slot from the head
    in_queue = 1'b0;
    for (int i = 0; i < MISSQ_ENTRIES; i++) begin
      offs = PTR_W'(i) - head;
      if (offs < occupancy && addr_q[i] == req_addr_i && asid_q[i] == req_asid_i) begin
        in_queue = 1'b1;
      end
    end
  end

  assign push = miss_req_i && !in_queue && room;   // Anything else is dropped
  assign pop  = missack_i && miss_o;                // A stray acknowledge is ignored

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      addr_q[tail] <= req_addr_i;
      asid_q[tail] <= req_asid_i;
      rob_q[tail]  <= req_rob_i;
    end
  end

  // Head presentation toward the page walker
  assign miss_o      = occupancy != '0;
  assign miss_addr_o = addr_q[head];
  assign miss_asid_o = asid_q[head];
  assign miss_rob_o  = rob_q[head];

endmodule

/* hdl/tlb_top.sv */
// Two-way set-associative data TLB with boot fill, read-back and a miss queue for the page walker
module tlb_top #(
  parameter int TLB_SETS      = 128,
  parameter int MISSQ_ENTRIES = 16
) (
  input  logic              clk,
  input  logic              rst,
  // External write port
  input  logic              wr_i,
  input  logic              wr_way_i,
  input  tlb_pkg::set_idx_t wr_set_i,
  input  tlb_pkg::vtag_t    wr_tag_i,
  input  tlb_pkg::asid_t    wr_asid_i,
  input  tlb_pkg::ppn_t     wr_ppn_i,
  input  tlb_pkg::rwx_t     wr_rwx_i,
  input  tlb_pkg::rgn_t     wr_rgn_i,
  input  logic              wr_v_i,
  // Read-back port
  input  tlb_pkg::set_idx_t rd_set_i,
  input  logic              rd_way_i,
  output tlb_pkg::vtag_t    rd_tag_o,
  output tlb_pkg::asid_t    rd_asid_o,
  output tlb_pkg::ppn_t     rd_ppn_o,
  output tlb_pkg::rwx_t     rd_rwx_o,
  output tlb_pkg::rgn_t     rd_rgn_o,
  output logic              rd_v_o,
  // Lookup from address generation
  input  logic              valid_i,
  input  logic              stall_i,
  input  logic              load_i,
  input  logic              store_i,
  input  tlb_pkg::vaddr_t   vaddr_i,
  input  tlb_pkg::asid_t    asid_i,
  input  tlb_pkg::rob_ndx_t rob_i,
  output logic              valid_o,
  output logic              load_o,
  output logic              store_o,
  output tlb_pkg::vaddr_t   vaddr_o,
  output tlb_pkg::rob_ndx_t rob_o,
  output tlb_pkg::ppn_t     ppn_o,
  output tlb_pkg::rwx_t     rwx_o,
  output tlb_pkg::rgn_t     rgn_o,
  // Page walker side
  output logic              miss_o,
  output tlb_pkg::vaddr_t   miss_addr_o,
  output tlb_pkg::asid_t    miss_asid_o,
  output tlb_pkg::rob_ndx_t miss_rob_o,
  input  logic              missack_i,
  output logic              fill_done_o
);

  // Storage write port after the fill select
  logic              sw_wr;
  logic              sw_way;
  tlb_pkg::set_idx_t sw_set;
  tlb_pkg::vtag_t    sw_tag;
  tlb_pkg::asid_t    sw_asid;
  tlb_pkg::ppn_t     sw_ppn;
  tlb_pkg::rwx_t     sw_rwx;
  tlb_pkg::rgn_t     sw_rgn;
  logic              sw_v;
  // Both ways of the lookup set
  tlb_pkg::vtag_t    w0_tag,  w1_tag;
  tlb_pkg::asid_t    w0_asid, w1_asid;
  tlb_pkg::ppn_t     w0_ppn,  w1_ppn;
  tlb_pkg::rwx_t     w0_rwx,  w1_rwx;
  tlb_pkg::rgn_t     w0_rgn,  w1_rgn;
  logic              w0_v,    w1_v;
  // Miss request into the queue
  logic              mr_req;
  tlb_pkg::vaddr_t   mr_addr;
  tlb_pkg::asid_t    mr_asid;
  tlb_pkg::rob_ndx_t mr_rob;

  tlb_init_fill #(.TLB_SETS(TLB_SETS)) u_init_fill (
    .clk(clk), .rst(rst),
    .wr_i(wr_i), .way_i(wr_way_i), .set_i(wr_set_i), .tag_i(wr_tag_i),
    .asid_i(wr_asid_i), .ppn_i(wr_ppn_i), .rwx_i(wr_rwx_i), .rgn_i(wr_rgn_i),
    .v_i(wr_v_i),
    .wr_o(sw_wr), .way_o(sw_way), .set_o(sw_set), .tag_o(sw_tag),
    .asid_o(sw_asid), .ppn_o(sw_ppn), .rwx_o(sw_rwx), .rgn_o(sw_rgn),
    .v_o(sw_v), .fill_done_o(fill_done_o)
  );

  tlb_ways #(.TLB_SETS(TLB_SETS)) u_ways (
    .clk(clk), .rst(rst),
    .wr_i(sw_wr), .way_i(sw_way), .set_i(sw_set), .tag_i(sw_tag),
    .asid_i(sw_asid), .ppn_i(sw_ppn), .rwx_i(sw_rwx), .rgn_i(sw_rgn), .v_i(sw_v),
    .look_set_i(vaddr_i[22:16]),         // Set index bits of the lookup address
    .rd_set_i(rd_set_i), .rd_way_i(rd_way_i),
    .w0_tag_o(w0_tag), .w0_asid_o(w0_asid), .w0_ppn_o(w0_ppn),
    .w0_rwx_o(w0_rwx), .w0_rgn_o(w0_rgn), .w0_v_o(w0_v),
    .w1_tag_o(w1_tag), .w1_asid_o(w1_asid), .w1_ppn_o(w1_ppn),
    .w1_rwx_o(w1_rwx), .w1_rgn_o(w1_rgn), .w1_v_o(w1_v),
    .rd_tag_o(rd_tag_o), .rd_asid_o(rd_asid_o), .rd_ppn_o(rd_ppn_o),
    .rd_rwx_o(rd_rwx_o), .rd_rgn_o(rd_rgn_o), .rd_v_o(rd_v_o)
  );

  tlb_lookup u_lookup (
    .clk(clk), .rst(rst),
    .valid_i(valid_i), .stall_i(stall_i), .load_i(load_i), .store_i(store_i),
    .vaddr_i(vaddr_i), .asid_i(asid_i), .rob_i(rob_i),
    .w0_tag_i(w0_tag), .w0_asid_i(w0_asid), .w0_ppn_i(w0_ppn),
    .w0_rwx_i(w0_rwx), .w0_rgn_i(w0_rgn), .w0_v_i(w0_v),
    .w1_tag_i(w1_tag), .w1_asid_i(w1_asid), .w1_ppn_i(w1_ppn),
    .w1_rwx_i(w1_rwx), .w1_rgn_i(w1_rgn), .w1_v_i(w1_v),
    .valid_o(valid_o), .load_o(load_o), .store_o(store_o),
    .vaddr_o(vaddr_o), .rob_o(rob_o),
    .ppn_o(ppn_o), .rwx_o(rwx_o), .rgn_o(rgn_o),
    .miss_req_o(mr_req), .miss_addr_o(mr_addr),
    .miss_asid_o(mr_asid), .miss_rob_o(mr_rob)
  );

  tlb_miss_queue #(.MISSQ_ENTRIES(MISSQ_ENTRIES)) u_miss_queue (
    .clk(clk), .rst(rst),
    .miss_req_i(mr_req), .req_addr_i(mr_addr),
    .req_asid_i(mr_asid), .req_rob_i(mr_rob),
    .missack_i(missack_i),
    .miss_o(miss_o), .miss_addr_o(miss_addr_o),
    .miss_asid_o(miss_asid_o), .miss_rob_o(miss_rob_o)
  );

endmodule

/* test/tlb_props.sv */
// Concurrent checks on the TLB miss queue reset state, occupancy and head stability
module tlb_miss_props #(
  parameter int MISSQ_ENTRIES = 16
) (
  input logic                             clk,
  input logic                             rst,
  input logic                             missack_i,
  input logic                             miss_i,        // Queue not empty
  input logic [$clog2(MISSQ_ENTRIES)-1:0] occupancy_i,
  input tlb_pkg::vaddr_t                  head_addr_i,
  input tlb_pkg::asid_t                   head_asid_i,
  input tlb_pkg::rob_ndx_t                head_rob_i
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PTR_W = $clog2(MISSQ_ENTRIES);

  // The queue comes out of reset empty
  assert property (@(posedge clk) rst |=> !miss_i)
    else $error("miss queue reports a miss right after reset");

  // Three slots stay in reserve at all times
  assert property (@(posedge clk) disable iff (rst)
                   occupancy_i <= PTR_W'(MISSQ_ENTRIES - 3))
    else $error("miss queue occupancy went past its limit");

  // The page walker sees a steady head until it acknowledges it
  assert property (@(posedge clk) disable iff (rst)
                   (miss_i && !missack_i) |=> ($stable(head_addr_i) && $stable(head_asid_i)
                                               && $stable(head_rob_i)))
    else $error("head of the miss queue changed without an acknowledge");

endmodule

bind tlb_miss_queue tlb_miss_props #(.MISSQ_ENTRIES(MISSQ_ENTRIES)) miss_props_inst (
  .clk(clk), .rst(rst), .missack_i(missack_i), .miss_i(miss_o), .occupancy_i(occupancy),
  .head_addr_i(miss_addr_o), .head_asid_i(miss_asid_o), .head_rob_i(miss_rob_o)
);

/* test/tlb_tb.sv */
// Data-driven testbench for the two-way data TLB, its boot fill and its miss queue
module tlb_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk, rst;
  logic wr_i, wr_way_i, wr_v_i;
  tlb_pkg::set_idx_t wr_set_i, rd_set_i;
  tlb_pkg::vtag_t    wr_tag_i, rd_tag_o;
  tlb_pkg::asid_t    wr_asid_i, rd_asid_o, asid_i, miss_asid_o;
  tlb_pkg::ppn_t     wr_ppn_i, rd_ppn_o, ppn_o;
  tlb_pkg::rwx_t     wr_rwx_i, rd_rwx_o, rwx_o;
  tlb_pkg::rgn_t     wr_rgn_i, rd_rgn_o, rgn_o;
  logic rd_way_i, rd_v_o;
  logic valid_i, stall_i, load_i, store_i, valid_o, load_o, store_o;
  tlb_pkg::vaddr_t   vaddr_i, vaddr_o, miss_addr_o;
  tlb_pkg::rob_ndx_t rob_i, rob_o, miss_rob_o;
  logic miss_o, missack_i, fill_done_o;

  int             fd;
  int             code;
  int             gap;             // Idle cycles after a lookup
  integer         seed;
  logic [7:0]     cmd;
  logic [1023:0]  line;            // Rest of a comment line
  logic [31:0]    p0, p1, p2, p3, p4, p5, p6, p7, p8;

  // Entries as they were written, used to tell which way a hit came from
  tlb_pkg::ppn_t     model_ppn [2][128];
  tlb_pkg::rgn_t     model_rgn [2][128];

  tlb_top tlb_top_inst (
    .clk(clk), .rst(rst),
    .wr_i(wr_i), .wr_way_i(wr_way_i), .wr_set_i(wr_set_i), .wr_tag_i(wr_tag_i),
    .wr_asid_i(wr_asid_i), .wr_ppn_i(wr_ppn_i), .wr_rwx_i(wr_rwx_i),
    .wr_rgn_i(wr_rgn_i), .wr_v_i(wr_v_i),
    .rd_set_i(rd_set_i), .rd_way_i(rd_way_i), .rd_tag_o(rd_tag_o), .rd_asid_o(rd_asid_o),
    .rd_ppn_o(rd_ppn_o), .rd_rwx_o(rd_rwx_o), .rd_rgn_o(rd_rgn_o), .rd_v_o(rd_v_o),
    .valid_i(valid_i), .stall_i(stall_i), .load_i(load_i), .store_i(store_i),
    .vaddr_i(vaddr_i), .asid_i(asid_i), .rob_i(rob_i),
    .valid_o(valid_o), .load_o(load_o), .store_o(store_o), .vaddr_o(vaddr_o),
    .rob_o(rob_o), .ppn_o(ppn_o), .rwx_o(rwx_o), .rgn_o(rgn_o),
    .miss_o(miss_o), .miss_addr_o(miss_addr_o), .miss_asid_o(miss_asid_o),
    .miss_rob_o(miss_rob_o), .missack_i(missack_i), .fill_done_o(fill_done_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;        // 100 ns period
  end

  // ==========================================================================
  // Failure reporting and checks
  // ==========================================================================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run("a DUT output does not match its expected value");
    end
  endtask

  task automatic wait_fill_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!fill_done_o) begin
      if (cycles == 50) abort_run("timeout, the boot fill did not finish within 50 cycles");
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic wait_for_miss();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!miss_o) begin
      if (cycles == 50) abort_run("timeout, no miss showed up on miss_o within 50 cycles");
      cycles++;
      @(negedge clk);
    end
  endtask

  // Boot entries sit in way 0 of sets 116 to 127, one page each from FFF4
  task automatic load_boot_model();
    for (int s = 116; s < 128; s++) begin
      model_ppn[0][s] = 16'hFFF4 + 16'(s - 116);
      if (s == 116 || s >= 125) begin
        model_rgn[0][s] = 3'd7;        // ROM
      end else if (s <= 120) begin
        model_rgn[0][s] = 3'd6;        // IO
      end else begin
        model_rgn[0][s] = 3'd4;        // Scratchpad
      end
    end
  endtask

  // ==========================================================================
  // Commands of the stimulus file
  // ==========================================================================

  task automatic write_entry();
    code = $fscanf(fd, "%h %h %h %h %h %h %h %h", p0, p1, p2, p3, p4, p5, p6, p7);
    if (code != 8) abort_run("malformed W line in the stimulus file");
    wr_i      = 1'b1;
    wr_way_i  = p0[0];
    wr_set_i  = p1[6:0];
    wr_tag_i  = p2[8:0];
    wr_asid_i = p3[7:0];
    wr_ppn_i  = p4[15:0];
    wr_rwx_i  = p5[2:0];
    wr_rgn_i  = p6[2:0];
    wr_v_i    = p7[0];
    model_ppn[p0[0]][p1[6:0]] = p4[15:0];
    model_rgn[p0[0]][p1[6:0]] = p6[2:0];
    @(posedge clk);                // Registered by the fill block
    #1 wr_i = 1'b0;
    @(posedge clk);                // Stored in the ways
    #1;
  endtask

  task automatic read_back();
    code = $fscanf(fd, "%h %h %h %h %h %h %h %h", p0, p1, p2, p3, p4, p5, p6, p7);
    if (code != 8) abort_run("malformed R line in the stimulus file");
    rd_way_i = p0[0];
    rd_set_i = p1[6:0];
    @(negedge clk);
    check_value("rd_tag_o", 32'(rd_tag_o), p2);
    check_value("rd_asid_o", 32'(rd_asid_o), p3);
    check_value("rd_ppn_o", 32'(rd_ppn_o), p4);
    check_value("rd_rwx_o", 32'(rd_rwx_o), p5);
    check_value("rd_rgn_o", 32'(rd_rgn_o), p6);
    check_value("rd_v_o", 32'(rd_v_o), p7);
    @(posedge clk);
    #1;
  endtask

  task automatic run_lookup();
    logic hit_way;                 // Way whose written page matches the expected one
    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", p0, p1, p2, p3, p4, p5, p6, p7, p8);
    if (code != 9) abort_run("malformed L line in the stimulus file");
    valid_i = 1'b1;
    vaddr_i = p0;
    asid_i  = p1[7:0];
    rob_i   = p2[5:0];
    load_i  = p3[0];
    store_i = p4[0];
    stall_i = p5[0];
    @(posedge clk);                // Lookup taken at this edge
    #1 valid_i = 1'b0;
    stall_i = 1'b0;
    @(negedge clk);
    check_value("valid_o", 32'(valid_o), 32'(p6[0] & ~p5[0]));   // Stall hides a hit
    if (p6[0] && !p5[0]) begin
      hit_way = (model_ppn[0][p0[22:16]] === p7[15:0]) ? 1'b0 : 1'b1;
      check_value("vaddr_o", vaddr_o, p0);
      check_value("rob_o", 32'(rob_o), p2);
      check_value("load_o", 32'(load_o), p3);
      check_value("store_o", 32'(store_o), p4);
      check_value("ppn_o", 32'(ppn_o), p7);
      check_value("rwx_o", 32'(rwx_o), p8);
      check_value("rgn_o", 32'(rgn_o), 32'(model_rgn[hit_way][p0[22:16]]));
    end
    gap = 1 + int'($unsigned($random(seed)) % 3);
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic ack_miss();
    code = $fscanf(fd, "%h %h %h %h", p0, p1, p2, p3);
    if (code != 4) abort_run("malformed A line in the stimulus file");
    if (p0[0]) begin
      wait_for_miss();
      check_value("miss_addr_o", miss_addr_o, p1);
      check_value("miss_asid_o", 32'(miss_asid_o), p2);
      check_value("miss_rob_o", 32'(miss_rob_o), p3);
      @(posedge clk);
      #1 missack_i = 1'b1;
      @(posedge clk);              // Head leaves the queue here
      #1 missack_i = 1'b0;
    end else begin
      @(negedge clk);
      check_value("miss_o", 32'(miss_o), 32'd0);   // Queue must be empty
      @(posedge clk);
      #1;
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    seed = 14;
    rst = 1'b1;
    {wr_i, wr_way_i, wr_v_i, rd_way_i, missack_i} = '0;
    {valid_i, stall_i, load_i, store_i} = '0;
    wr_set_i = '0;
    wr_tag_i = '0;
    wr_asid_i = '0;
    wr_ppn_i = '0;
    wr_rwx_i = '0;
    wr_rgn_i = '0;
    rd_set_i = '0;
    vaddr_i = '0;
    asid_i = '0;
    rob_i = '0;
    load_boot_model();
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    check_value("fill_done_o", 32'(fill_done_o), 32'd0);   // Outputs idle out of reset
    check_value("valid_o", 32'(valid_o), 32'd0);
    check_value("miss_o", 32'(miss_o), 32'd0);
    wait_fill_done();
    @(posedge clk);
    #1;
    fd = $fopen("test/tlb_input.txt", "r");
    if (fd == 0) abort_run("cannot open the stimulus file test/tlb_input.txt");
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", cmd);
      if (code == 1) begin
        case (cmd)
          "#":     code = $fgets(line, fd);
          "W":     write_entry();
          "R":     read_back();
          "L":     run_lookup();
          "A":     ack_miss();
          default: abort_run("unknown command letter in the stimulus file");
        endcase
      end
    end
    $fclose(fd);
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* sources.f */
hdl/tlb_pkg.sv
hdl/tlb_init_fill.sv
hdl/tlb_ways.sv
hdl/tlb_lookup.sv
hdl/tlb_miss_queue.sv
hdl/tlb_top.sv
test/tlb_props.sv
test/tlb_tb.sv

/* Makefile */
# Verilator build and run of the data TLB testbench
TOP := tlb_tb

.PHONY: all lint clean

# Build, then run; a failing run ends in $$fatal and a nonzero exit status
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f hdl/*.sv test/*.sv
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	  -f sources.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
	  -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* test/tlb_input.txt */
# W way set tag asid ppn rwx rgn v  writes an entry, R with the same columns reads back
# L vaddr asid rob ld st stall hit ppn rwx  and  A present addr asid rob, all in hex
# Boot entries in way 0 of sets 116 to 127
R 0 74 1ff 00 fff4 7 7 1
R 0 75 1ff 00 fff5 7 6 1
R 0 76 1ff 00 fff6 7 6 1
R 0 77 1ff 00 fff7 7 6 1
R 0 78 1ff 00 fff8 7 6 1
R 0 79 1ff 00 fff9 7 4 1
R 0 7a 1ff 00 fffa 7 4 1
R 0 7b 1ff 00 fffb 7 4 1
R 0 7c 1ff 00 fffc 7 4 1
R 0 7d 1ff 00 fffd 7 7 1
R 0 7e 1ff 00 fffe 7 7 1
R 0 7f 1ff 00 ffff 7 7 1
L fff40000 00 01 1 0 0 1 fff4 7
L ffff0000 00 02 0 1 0 1 ffff 7
# External write, read-back and hits with load and store flags
W 0 10 012 05 1234 3 2 1
R 0 10 012 05 1234 3 2 1
L 09100abc 05 0a 1 0 0 1 1234 3
L 09100abc 05 0b 0 1 0 1 1234 3
# Same tag in both ways, asid picks the way, then way 0 wins
W 0 20 0aa 01 2000 1 0 1
W 1 20 0aa 02 3000 5 1 1
L 55200040 02 0c 1 0 0 1 3000 5
L 55200040 01 0d 1 0 0 1 2000 1
W 1 20 0aa 01 4000 6 1 1
R 1 20 0aa 01 4000 6 1 1
L 55200040 01 0e 0 1 0 1 2000 1
# Repeated miss is queued once
L 12300100 07 11 1 0 0 0 0 0
L 12300100 07 12 0 1 0 0 0 0
A 1 12300100 07 11
A 0 0 0 0
# Three misses in order, stalled lookup queues nothing
L 00400000 03 20 1 0 0 0 0 0
L 00410000 03 21 1 0 0 0 0 0
L 00420000 03 22 0 1 0 0 0 0
L 00430000 03 23 1 0 1 0 0 0
A 1 00400000 03 20
A 1 00410000 03 21
A 1 00420000 03 22
A 0 0 0 0
# Fourteen misses, thirteen fit
L 00500000 04 30 1 0 0 0 0 0
L 00500010 04 31 1 0 0 0 0 0
L 00500020 04 32 1 0 0 0 0 0
L 00500030 04 33 1 0 0 0 0 0
L 00500040 04 34 1 0 0 0 0 0
L 00500050 04 35 1 0 0 0 0 0
L 00500060 04 36 1 0 0 0 0 0
L 00500070 04 37 1 0 0 0 0 0
L 00500080 04 38 1 0 0 0 0 0
L 00500090 04 39 1 0 0 0 0 0
L 005000a0 04 3a 1 0 0 0 0 0
L 005000b0 04 3b 1 0 0 0 0 0
L 005000c0 04 3c 1 0 0 0 0 0
L 005000d0 04 3d 1 0 0 0 0 0
A 1 00500000 04 30
A 1 00500010 04 31
A 1 00500020 04 32
A 1 00500030 04 33
A 1 00500040 04 34
A 1 00500050 04 35
A 1 00500060 04 36
A 1 00500070 04 37
A 1 00500080 04 38
A 1 00500090 04 39
A 1 005000a0 04 3a
A 1 005000b0 04 3b
A 1 005000c0 04 3c
A 0 0 0 0
